//--- project.f
issue_pkg.sv
phys_reg_file.sv
fu_fifo.sv
issue_stage.sv
issue_top.sv
tb_issue.sv

//--- Bender.yml
package:
  name: issue_stage

sources:
  - issue_pkg.sv
  - phys_reg_file.sv
  - fu_fifo.sv
  - issue_stage.sv
  - issue_top.sv
  - target: test
    files:
      - tb_issue.sv

//--- tb_issue.sv
`timescale 1ns/100ps
module tb_issue;

    localparam int depth       = 8;
    localparam int test_cycles = 16 + 20 + 200 + 30 + 20 + 10 + 20 + 20 + 4;

    logic                                               clock;
    logic                                               rst;
    issue_pkg::rs_packet_t [issue_pkg::issue_width-1:0] rs_out;
    issue_pkg::fu_ready_t                               fu_ready;
    issue_pkg::wb_packet_t                              wb;
    issue_pkg::issue_packet_t [2:0]                     issue_alu, exp_alu;
    issue_pkg::issue_packet_t [1:0]                     issue_mult, exp_mult;
    issue_pkg::issue_packet_t [1:0]                     issue_ls, exp_ls;
    issue_pkg::issue_packet_t                           issue_branch, exp_br;
    issue_pkg::fu_stall_t                               fu_fifo_stall, exp_stall;

    issue_pkg::issue_packet_t   exp_q [4][$];  // one per class with the oldest first
    logic [issue_pkg::xlen-1:0] shadow [issue_pkg::num_pr];
    int                         errors;
    int                         issue_pct;
    int                         slots;
    int                         rdy_mode;
    bit                         fix_cls;
    bit                         wb_on;
    string                      test_name;

    issue_top #(.fifo_depth(depth)) i_dut (
        .clock         (clock),
        .rst           (rst),
        .rs_out        (rs_out),
        .fu_ready      (fu_ready),
        .wb            (wb),
        .issue_alu     (issue_alu),
        .issue_mult    (issue_mult),
        .issue_ls      (issue_ls),
        .issue_branch  (issue_branch),
        .fu_fifo_stall (fu_fifo_stall)
    );

    initial begin
        clock = 1'b0;
        forever #20 clock = ~clock;
    end

    function automatic bit ready_bit(input int c, input int k);
        case (c)
            0: return fu_ready.alu[k];
            1: return fu_ready.mult[k];
            2: return fu_ready.ls[k];
            default: return fu_ready.branch;
        endcase
    endfunction

    function automatic bit stalled(input int c);
        return exp_q[c].size() > depth - 3;
    endfunction

    function automatic issue_pkg::issue_packet_t head_at(input int c, input int k);
        if (k < exp_q[c].size()) begin
            return exp_q[c][k];
        end
        return '0;
    endfunction

    // an empty port only has to show valid low
    function automatic bit port_matches(input issue_pkg::issue_packet_t got,
                                        input issue_pkg::issue_packet_t want);
        if (got.valid != want.valid) begin
            return 1'b0;
        end
        return !want.valid || (got == want);
    endfunction

    function automatic issue_pkg::issue_packet_t expect_pkt(input issue_pkg::rs_packet_t p);
        issue_pkg::issue_packet_t e;
        e = '{valid: 1'b1, op_sel: p.op_sel, pc: p.pc, npc: p.npc, inst: p.inst,
              dest_pr: p.dest_pr, rob_entry: p.rob_entry, opa_select: p.opa_select,
              opb_select: p.opb_select, halt: p.halt, r1_value: shadow[p.reg1_pr],
              r2_value: shadow[p.reg2_pr]};  // shadow p0 stays zero
        return e;
    endfunction

    function automatic issue_pkg::rs_packet_t random_rs(input issue_pkg::fu_class_t cls);
        issue_pkg::rs_packet_t p;
        p            = '0;
        p.valid      = 1'b1;
        p.fu_sel     = cls;
        p.op_sel     = issue_pkg::alu_op_t'(4'($urandom_range(11)));
        p.pc         = $urandom;
        p.npc        = p.pc + 4;
        p.inst       = $urandom;
        p.reg1_pr    = issue_pkg::pr_bits'($urandom);
        p.reg2_pr    = issue_pkg::pr_bits'($urandom_range(7));  // hits p0 often
        p.dest_pr    = issue_pkg::pr_bits'($urandom);
        p.rob_entry  = issue_pkg::rob_bits'($urandom);
        p.opa_select = 2'($urandom);
        p.opb_select = 2'($urandom);
        p.halt       = 1'($urandom);
        return p;
    endfunction

    function automatic issue_pkg::fu_ready_t ready_pattern(input int mode);
        case (mode)
            1: return '0;
            2: return '1;
            3: return {3'b110, 2'b10, 2'b10, 1'b0};  // port 0 held while later ports are ready
            default: return issue_pkg::fu_ready_t'(8'($urandom));
        endcase
    endfunction

    task automatic drive_next();
        issue_pkg::rs_packet_t [issue_pkg::issue_width-1:0] nxt;
        issue_pkg::fu_class_t                               cls;
        nxt = '0;
        for (int s = 0; s < slots; s++) begin
            cls = fix_cls ? issue_pkg::fu_mult : issue_pkg::fu_class_t'(2'($urandom_range(3)));
            if (($urandom_range(99) < issue_pct) && !stalled(int'(cls))) begin
                nxt[s] = random_rs(cls);
            end
        end
        rs_out   <= nxt;
        fu_ready <= ready_pattern(rdy_mode);
        wb       <= {wb_on, issue_pkg::pr_bits'($urandom), issue_pkg::xlen'($urandom)};
    endtask

    // reference model update at one clock edge and the next inputs
    task automatic tick();
        int n;
        @(posedge clock);
        if (rst) begin
            for (int c = 0; c < 4; c++) begin
                exp_q[c].delete();
            end
            shadow = '{default: '0};
        end else begin
            for (int c = 0; c < 4; c++) begin
                n = 0;
                while (n < (c == 0 ? 3 : (c == 3 ? 1 : 2)) && n < exp_q[c].size()
                       && ready_bit(c, n)) begin
                    n++;
                end
                repeat (n) void'(exp_q[c].pop_front());  // leading run only
            end
            for (int s = 0; s < issue_pkg::issue_width; s++) begin
                if (rs_out[s].valid) begin
                    exp_q[int'(rs_out[s].fu_sel)].push_back(expect_pkt(rs_out[s]));
                end
            end
            if (wb.valid && wb.dest_pr != '0) begin
                shadow[wb.dest_pr] = wb.value;  // after the reads
            end
        end
        exp_alu   = {head_at(0, 2), head_at(0, 1), head_at(0, 0)};
        exp_mult  = {head_at(1, 1), head_at(1, 0)};
        exp_ls    = {head_at(2, 1), head_at(2, 0)};
        exp_br    = head_at(3, 0);
        exp_stall = {stalled(0), stalled(1), stalled(2), stalled(3)};
        drive_next();
    endtask

    task automatic flag_mismatch(input string port, input string expv, input string actv);
        errors++;
        $display("Fail %s %s expected %s actual %s", test_name, port, expv, actv);
    endtask

    task automatic note_problem(input string msg);
        errors++;
        $display("during %s: %s", test_name, msg);
    endtask

    alu_match: assert property (@(posedge clock) disable iff (rst)
        port_matches(issue_alu[0], exp_alu[0]) && port_matches(issue_alu[1], exp_alu[1])
        && port_matches(issue_alu[2], exp_alu[2]))
        else flag_mismatch("alu", $sformatf("%h", $sampled(exp_alu)),
                           $sformatf("%h", $sampled(issue_alu)));
    mult_match: assert property (@(posedge clock) disable iff (rst)
        port_matches(issue_mult[0], exp_mult[0])
        && port_matches(issue_mult[1], exp_mult[1]))
        else flag_mismatch("mult", $sformatf("%h", $sampled(exp_mult)),
                           $sformatf("%h", $sampled(issue_mult)));
    ls_match: assert property (@(posedge clock) disable iff (rst)
        port_matches(issue_ls[0], exp_ls[0]) && port_matches(issue_ls[1], exp_ls[1]))
        else flag_mismatch("ls", $sformatf("%h", $sampled(exp_ls)),
                           $sformatf("%h", $sampled(issue_ls)));
    br_match: assert property (@(posedge clock) disable iff (rst)
        port_matches(issue_branch, exp_br))
        else flag_mismatch("branch", $sformatf("%h", $sampled(exp_br)),
                           $sformatf("%h", $sampled(issue_branch)));
    stall_match: assert property (@(posedge clock) disable iff (rst) fu_fifo_stall == exp_stall)
        else flag_mismatch("stall", $sformatf("%b", $sampled(exp_stall)),
                           $sformatf("%b", $sampled(fu_fifo_stall)));

    reset_state: assert property (@(posedge clock) rst |=> fu_fifo_stall == '0
        && !(issue_alu[0].valid || issue_alu[1].valid || issue_alu[2].valid)
        && !(issue_mult[0].valid || issue_mult[1].valid || issue_ls[0].valid)
        && !(issue_ls[1].valid || issue_branch.valid))
        else note_problem("an output valid or stall bit was high after reset");

    // into an empty queue the packet shows on port 0 next cycle
    mult_latency: assert property (@(posedge clock) disable iff (rst)
        rs_out[0].valid && rs_out[0].fu_sel == issue_pkg::fu_mult && !issue_mult[0].valid
        |=> issue_mult[0].valid)
        else note_problem("mult packet missing from port 0 one cycle after issue");
    br_latency: assert property (@(posedge clock) disable iff (rst)
        rs_out[0].valid && rs_out[0].fu_sel == issue_pkg::fu_branch && !issue_branch.valid
        |=> issue_branch.valid)
        else note_problem("branch packet missing from its port one cycle after issue");

    for (genvar i = 0; i < 3; i++) begin : g_alu_hold
        assert property (@(posedge clock) disable iff (rst)
            issue_alu[i].valid && !fu_ready.alu[0] |=> $stable(issue_alu[i]))
            else note_problem($sformatf("alu port %0d changed while port 0 was held", i));
    end
    for (genvar i = 0; i < 2; i++) begin : g_pair_hold
        assert property (@(posedge clock) disable iff (rst)
            issue_mult[i].valid && !fu_ready.mult[0] |=> $stable(issue_mult[i]))
            else note_problem($sformatf("mult port %0d changed while port 0 was held", i));
        assert property (@(posedge clock) disable iff (rst)
            issue_ls[i].valid && !fu_ready.ls[0] |=> $stable(issue_ls[i]))
            else note_problem($sformatf("ls port %0d changed while port 0 was held", i));
    end
    br_hold: assert property (@(posedge clock) disable iff (rst)
        issue_branch.valid && !fu_ready.branch |=> $stable(issue_branch))
        else note_problem("branch port changed while it was held");

    initial begin
        #(40 * (test_cycles + 100));
        $display("watchdog expired, the run did not finish in %0d cycles", test_cycles + 100);
        $display("Errors found");
        $finish;
    end

    initial begin
        void'($urandom(26883));
        rst       = 1'b1;
        rs_out    = '0;
        fu_ready  = '0;
        wb        = '0;
        errors    = 0;
        issue_pct = 0;
        slots     = 3;
        rdy_mode  = 2;
        fix_cls   = 1'b0;
        wb_on     = 1'b0;
        test_name = "reset";
        repeat (16) tick();
        rst <= 1'b0;
        test_name = "operand read";
        wb_on     = 1'b1;
        repeat (20) tick();
        test_name = "steering";
        issue_pct = 60;
        rdy_mode  = 0;
        repeat (200) tick();
        test_name = "back-pressure";
        rdy_mode  = 3;
        repeat (30) tick();
        issue_pct = 0;
        rdy_mode  = 2;
        repeat (20) tick();
        test_name = "stall";
        fix_cls   = 1'b1;
        issue_pct = 100;
        rdy_mode  = 1;  // mult queue fills
        repeat (10) tick();
        issue_pct = 0;
        rdy_mode  = 2;
        repeat (20) tick();
        test_name = "latency";
        fix_cls   = 1'b0;
        slots     = 1;
        issue_pct = 50;
        repeat (20) tick();
        issue_pct = 0;
        repeat (4) tick();
        $display("checks finished with %0d errors", errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

//--- issue_top.sv
`timescale 1ns/100ps
module issue_top #(
    parameter int fifo_depth = 8
) (
    input  logic                                               clock,
    input  logic                                               rst,
    input  issue_pkg::rs_packet_t [issue_pkg::issue_width-1:0] rs_out,
    input  issue_pkg::fu_ready_t                               fu_ready,
    input  issue_pkg::wb_packet_t                              wb,
    output issue_pkg::issue_packet_t [2:0]                     issue_alu,
    output issue_pkg::issue_packet_t [1:0]                     issue_mult,
    output issue_pkg::issue_packet_t [1:0]                     issue_ls,
    output issue_pkg::issue_packet_t                           issue_branch,
    output issue_pkg::fu_stall_t                               fu_fifo_stall
);

    logic [issue_pkg::issue_width-1:0][issue_pkg::pr_bits-1:0] rda_idx;
    logic [issue_pkg::issue_width-1:0][issue_pkg::pr_bits-1:0] rdb_idx;
    logic [issue_pkg::issue_width-1:0][issue_pkg::xlen-1:0]    read_rda;
    logic [issue_pkg::issue_width-1:0][issue_pkg::xlen-1:0]    read_rdb;

    phys_reg_file i_prf (
        .clock    (clock),
        .rst      (rst),
        .rda_idx  (rda_idx),
        .rdb_idx  (rdb_idx),
        .wb       (wb),  // result path stand-in
        .read_rda (read_rda),
        .read_rdb (read_rdb)
    );

    issue_stage #(.fifo_depth(fifo_depth)) i_issue (
        .clock         (clock),
        .rst           (rst),
        .rs_out        (rs_out),
        .read_rda      (read_rda),
        .read_rdb      (read_rdb),
        .fu_ready      (fu_ready),
        .rda_idx       (rda_idx),
        .rdb_idx       (rdb_idx),
        .issue_alu     (issue_alu),
        .issue_mult    (issue_mult),
        .issue_ls      (issue_ls),
        .issue_branch  (issue_branch),
        .fu_fifo_stall (fu_fifo_stall)
    );

endmodule

//--- issue_stage.sv
`timescale 1ns/100ps
module issue_stage #(
    parameter int fifo_depth = 8
) (
    input  logic                                                    clock,
    input  logic                                                    rst,
    input  issue_pkg::rs_packet_t [issue_pkg::issue_width-1:0]      rs_out,
    input  logic [issue_pkg::issue_width-1:0][issue_pkg::xlen-1:0]    read_rda,
    input  logic [issue_pkg::issue_width-1:0][issue_pkg::xlen-1:0]    read_rdb,
    input  issue_pkg::fu_ready_t                                    fu_ready,
    output logic [issue_pkg::issue_width-1:0][issue_pkg::pr_bits-1:0] rda_idx,
    output logic [issue_pkg::issue_width-1:0][issue_pkg::pr_bits-1:0] rdb_idx,
    output issue_pkg::issue_packet_t [2:0]                          issue_alu,
    output issue_pkg::issue_packet_t [1:0]                          issue_mult,
    output issue_pkg::issue_packet_t [1:0]                          issue_ls,
    output issue_pkg::issue_packet_t                                issue_branch,
    output issue_pkg::fu_stall_t                                    fu_fifo_stall
);

    issue_pkg::issue_packet_t [issue_pkg::issue_width-1:0] issue;
    issue_pkg::issue_packet_t [issue_pkg::issue_width-1:0] alu_in;
    issue_pkg::issue_packet_t [issue_pkg::issue_width-1:0] mult_in;
    issue_pkg::issue_packet_t [issue_pkg::issue_width-1:0] ls_in;
    issue_pkg::issue_packet_t [issue_pkg::issue_width-1:0] br_in;

    always_comb begin
        for (int i = 0; i < issue_pkg::issue_width; i++) begin
            rda_idx[i] = rs_out[i].reg1_pr;
            rdb_idx[i] = rs_out[i].reg2_pr;

            issue[i].valid      = rs_out[i].valid;
            issue[i].op_sel     = rs_out[i].op_sel;
            issue[i].pc         = rs_out[i].pc;
            issue[i].npc        = rs_out[i].npc;
            issue[i].inst       = rs_out[i].inst;
            issue[i].dest_pr    = rs_out[i].dest_pr;
            issue[i].rob_entry  = rs_out[i].rob_entry;
            issue[i].opa_select = rs_out[i].opa_select;
            issue[i].opb_select = rs_out[i].opb_select;
            issue[i].halt       = rs_out[i].halt;
            issue[i].r1_value   = read_rda[i];  // prf read is comb
            issue[i].r2_value   = read_rdb[i];
        end
    end

    // every queue sees every slot, valid only for its own class
    always_comb begin
        for (int i = 0; i < issue_pkg::issue_width; i++) begin
            alu_in[i]        = issue[i];
            mult_in[i]       = issue[i];
            ls_in[i]         = issue[i];
            br_in[i]         = issue[i];
            alu_in[i].valid  = issue[i].valid && (rs_out[i].fu_sel == issue_pkg::fu_alu);
            mult_in[i].valid = issue[i].valid && (rs_out[i].fu_sel == issue_pkg::fu_mult);
            ls_in[i].valid   = issue[i].valid && (rs_out[i].fu_sel == issue_pkg::fu_ls);
            br_in[i].valid   = issue[i].valid && (rs_out[i].fu_sel == issue_pkg::fu_branch);
        end
    end

    fu_fifo #(.depth(fifo_depth), .rd_ports(3)) alu_fifo (
        .clock       (clock),
        .rst         (rst),
        .pckt_in     (alu_in),
        .rd_en       (fu_ready.alu),
        .pckt_out    (issue_alu),
        .almost_full (fu_fifo_stall.alu)
    );

    fu_fifo #(.depth(fifo_depth), .rd_ports(2)) mult_fifo (
        .clock       (clock),
        .rst         (rst),
        .pckt_in     (mult_in),
        .rd_en       (fu_ready.mult),
        .pckt_out    (issue_mult),
        .almost_full (fu_fifo_stall.mult)
    );

    fu_fifo #(.depth(fifo_depth), .rd_ports(2)) ls_fifo (
        .clock       (clock),
        .rst         (rst),
        .pckt_in     (ls_in),
        .rd_en       (fu_ready.ls),
        .pckt_out    (issue_ls),
        .almost_full (fu_fifo_stall.ls)
    );

    fu_fifo #(.depth(fifo_depth), .rd_ports(1)) br_fifo (
        .clock       (clock),
        .rst         (rst),
        .pckt_in     (br_in),
        .rd_en       (fu_ready.branch),
        .pckt_out    (issue_branch),
        .almost_full (fu_fifo_stall.branch)
    );

endmodule

//--- fu_fifo.sv
`timescale 1ns/100ps
module fu_fifo #(
    parameter int depth    = 8,
    parameter int rd_ports = 3
) (
    input  logic                                                clock,
    input  logic                                                rst,
    input  issue_pkg::issue_packet_t [issue_pkg::issue_width-1:0] pckt_in,
    input  logic [rd_ports-1:0]                                 rd_en,
    output issue_pkg::issue_packet_t [rd_ports-1:0]             pckt_out,
    output logic                                                almost_full
);

    localparam int ptr_bits = $clog2(depth);
    localparam int cnt_bits = $clog2(depth + 1);

    issue_pkg::issue_packet_t mem [depth];

    logic [ptr_bits-1:0] head;
    logic [ptr_bits-1:0] tail;
    logic [cnt_bits-1:0] count;
    logic [cnt_bits-1:0] pop_cnt;
    logic [cnt_bits-1:0] push_cnt;
    logic [cnt_bits-1:0] free_cnt;
    logic                pop_run;

    logic [issue_pkg::issue_width-1:0]               wr_en;
    logic [issue_pkg::issue_width-1:0][ptr_bits-1:0] wr_idx;

    // circular index, offsets stay below depth
    function automatic logic [ptr_bits-1:0] wrap(
        input logic [ptr_bits-1:0] base,
        input int unsigned         offs
    );
        int unsigned sum;
        sum = base + offs;
        if (sum >= depth) begin
            sum = sum - depth;
        end
        return ptr_bits'(sum);
    endfunction

    // oldest entries on the low ports
    always_comb begin
        for (int i = 0; i < rd_ports; i++) begin
            if (i < count) begin
                pckt_out[i] = mem[wrap(head, i)];
            end else begin
                pckt_out[i] = '0;
            end
        end
    end

    // only a leading run of consumed ports pops
    always_comb begin
        pop_run = 1'b1;
        pop_cnt = '0;
        for (int i = 0; i < rd_ports; i++) begin
            pop_run = pop_run & rd_en[i] & pckt_out[i].valid;
            if (pop_run) begin
                pop_cnt = pop_cnt + 1'b1;
            end
        end
    end

    assign free_cnt = cnt_bits'(depth) - count + pop_cnt;

    // compact valid slots, slot 0 first
    always_comb begin
        push_cnt = '0;
        for (int k = 0; k < issue_pkg::issue_width; k++) begin
            wr_en[k]  = 1'b0;
            wr_idx[k] = wrap(tail, push_cnt);
            if (pckt_in[k].valid && (push_cnt < free_cnt)) begin
                wr_en[k] = 1'b1;
                push_cnt = push_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (rst) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            head  <= wrap(head, pop_cnt);
            tail  <= wrap(tail, push_cnt);
            count <= count + push_cnt - pop_cnt;
        end
    end

    always_ff @(posedge clock) begin
        for (int k = 0; k < issue_pkg::issue_width; k++) begin
            if (wr_en[k]) begin
                mem[wr_idx[k]] <= pckt_in[k];
            end
        end
    end

    // room for one more full issue group
    assign almost_full = (count > cnt_bits'(depth - issue_pkg::issue_width));

endmodule

//--- phys_reg_file.sv
`timescale 1ns/100ps
module phys_reg_file (
    input  logic                                                   clock,
    input  logic                                                   rst,
    input  logic [issue_pkg::issue_width-1:0][issue_pkg::pr_bits-1:0] rda_idx,
    input  logic [issue_pkg::issue_width-1:0][issue_pkg::pr_bits-1:0] rdb_idx,
    input  issue_pkg::wb_packet_t                                  wb,
    output logic [issue_pkg::issue_width-1:0][issue_pkg::xlen-1:0]    read_rda,
    output logic [issue_pkg::issue_width-1:0][issue_pkg::xlen-1:0]    read_rdb
);

    logic [issue_pkg::xlen-1:0] regs [issue_pkg::num_pr];

    always_ff @(posedge clock) begin
        if (rst) begin
            for (int r = 0; r < issue_pkg::num_pr; r++) begin
                regs[r] <= '0;
            end
        end else if (wb.valid && (wb.dest_pr != '0)) begin  // p0 is hardwired
            regs[wb.dest_pr] <= wb.value;
        end
    end

    // old value on a same-cycle write, no bypass
    always_comb begin
        for (int i = 0; i < issue_pkg::issue_width; i++) begin
            if (rda_idx[i] == '0) begin
                read_rda[i] = '0;
            end else begin
                read_rda[i] = regs[rda_idx[i]];
            end
            if (rdb_idx[i] == '0) begin
                read_rdb[i] = '0;
            end else begin
                read_rdb[i] = regs[rdb_idx[i]];
            end
        end
    end

endmodule

//--- issue_pkg.sv
package issue_pkg;

    parameter int xlen        = 32;
    parameter int num_pr      = 64;
    parameter int pr_bits     = $clog2(num_pr);
    parameter int rob_bits    = 5;
    parameter int issue_width = 3;

    typedef enum logic [1:0] {
        fu_alu,
        fu_mult,
        fu_ls,
        fu_branch
    } fu_class_t;

    typedef enum logic [3:0] {
        op_add,
        op_sub,
        op_and,
        op_or,
        op_xor,
        op_sll,
        op_srl,
        op_mul,
        op_load,
        op_store,
        op_beq,
        op_bne
    } alu_op_t;

    typedef struct packed {
        logic                valid;
        fu_class_t           fu_sel;
        alu_op_t             op_sel;
        logic [xlen-1:0]     pc;
        logic [xlen-1:0]     npc;
        logic [31:0]         inst;
        logic [pr_bits-1:0]  reg1_pr;
        logic [pr_bits-1:0]  reg2_pr;
        logic [pr_bits-1:0]  dest_pr;
        logic [rob_bits-1:0] rob_entry;
        logic [1:0]          opa_select;
        logic [1:0]          opb_select;
        logic                halt;
    } rs_packet_t;

    typedef struct packed {
        logic                valid;
        alu_op_t             op_sel;
        logic [xlen-1:0]     pc;
        logic [xlen-1:0]     npc;
        logic [31:0]         inst;
        logic [pr_bits-1:0]  dest_pr;
        logic [rob_bits-1:0] rob_entry;
        logic [1:0]          opa_select;
        logic [1:0]          opb_select;
        logic                halt;
        logic [xlen-1:0]     r1_value;  // source operands from the prf
        logic [xlen-1:0]     r2_value;
    } issue_packet_t;

    typedef struct packed {
        logic [2:0] alu;
        logic [1:0] mult;
        logic [1:0] ls;
        logic       branch;
    } fu_ready_t;

    typedef struct packed {
        logic alu;
        logic mult;
        logic ls;
        logic branch;
    } fu_stall_t;

    typedef struct packed {
        logic               valid;
        logic [pr_bits-1:0] dest_pr;
        logic [xlen-1:0]    value;
    } wb_packet_t;

endpackage
